// File: hdl/rv32m_pkg.sv
package rv32m_pkg;

    // funct3 field of the OP opcode when funct7 selects the M extension.
    localparam logic [2:0] FUNCT3_MUL    = 3'b000;
    localparam logic [2:0] FUNCT3_MULH   = 3'b001;
    localparam logic [2:0] FUNCT3_MULHSU = 3'b010;
    localparam logic [2:0] FUNCT3_MULHU  = 3'b011;
    localparam logic [2:0] FUNCT3_DIV    = 3'b100;
    localparam logic [2:0] FUNCT3_DIVU   = 3'b101;
    localparam logic [2:0] FUNCT3_REM    = 3'b110;
    localparam logic [2:0] FUNCT3_REMU   = 3'b111;

    // operation of the instruction currently in flight.
    typedef enum logic [2:0] {
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } mdu_op_e;

endpackage

// File: hdl/mdu_pkg.sv
package mdu_pkg;

    // operand width of the core, XLEN for RV32.
    localparam int XLEN_DEFAULT = 32;

    // control states of the iterative divider.
    typedef enum logic [1:0] {
        D_IDLE,     // waiting for a start strobe.
        D_INIT,     // load accumulator and quotient.
        D_CALC,     // one shift-subtract step per cycle.
        D_SIGN      // apply result signs.
    } div_states_e;

endpackage

// File: hdl/mdu_decode.sv
`timescale 1ns/1ps

module mdu_decode #(
    parameter int N = 32
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 valid_i,
    input  logic [2:0]           funct3_i,
    input  logic [N-1:0]         rs1_i,
    input  logic [N-1:0]         rs2_i,
    input  logic                 wb_valid_i,
    output logic                 busy_o,
    output logic                 mul_start_o,
    output logic                 div_start_o,
    output rv32m_pkg::mdu_op_e   op_o,
    output logic [N-1:0]         operand_a_o,
    output logic [N-1:0]         operand_b_o,
    output logic                 a_signed_o,
    output logic                 b_signed_o
);
    import rv32m_pkg::*;

    logic    in_flight;
    logic    accept;
    mdu_op_e op_dec;

    assign accept = valid_i & ~in_flight;   // strobes during busy are dropped.
    assign busy_o = in_flight;

    always_comb begin
        case (funct3_i)
            FUNCT3_MUL:    op_dec = OP_MUL;
            FUNCT3_MULH:   op_dec = OP_MULH;
            FUNCT3_MULHSU: op_dec = OP_MULHSU;
            FUNCT3_MULHU:  op_dec = OP_MULHU;
            FUNCT3_DIV:    op_dec = OP_DIV;
            FUNCT3_DIVU:   op_dec = OP_DIVU;
            FUNCT3_REM:    op_dec = OP_REM;
            FUNCT3_REMU:   op_dec = OP_REMU;
            default:       op_dec = OP_MUL;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_flight   <= 1'b0;
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
        end else begin
            mul_start_o <= accept & ~funct3_i[2];
            div_start_o <= accept &  funct3_i[2];   // upper half of funct3 is divide.
            if (accept)
                in_flight <= 1'b1;
            else if (wb_valid_i)
                in_flight <= 1'b0;
        end
    end

    // held until the next accepted issue.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o        <= op_dec;
            operand_a_o <= rs1_i;
            operand_b_o <= rs2_i;
            a_signed_o  <= (op_dec == OP_MULH) || (op_dec == OP_MULHSU) ||
                           (op_dec == OP_DIV)  || (op_dec == OP_REM);
            b_signed_o  <= (op_dec == OP_MULH) || (op_dec == OP_DIV) || (op_dec == OP_REM);
        end
    end

endmodule

// File: hdl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int N = 32
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           start_i,
    input  logic [N-1:0]   a_i,
    input  logic [N-1:0]   b_i,
    input  logic           a_signed_i,
    input  logic           b_signed_i,
    output logic           done_o,
    output logic [2*N-1:0] product_o
);

    logic signed [N:0]     a_ext;
    logic signed [N:0]     b_ext;
    logic signed [2*N+1:0] full_product;

    // one extra bit lets a single signed multiplier cover all three
    // signedness combinations.
    assign a_ext = {a_signed_i & a_i[N-1], a_i};
    assign b_ext = {b_signed_i & b_i[N-1], b_i};

    assign full_product = a_ext * b_ext;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;  // result is ready one cycle later.
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            product_o <= full_product[2*N-1:0];  // top two bits are only sign copies.
        end
    end

endmodule

// File: hdl/div_unit.sv
`timescale 1ns/1ps

module div_unit #(
    parameter int N = 32
) (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         start_i,
    input  logic [N-1:0] dividend_i,
    input  logic [N-1:0] divisor_i,
    input  logic         signed_i,
    output logic         done_o,
    output logic [N-1:0] quotient_o,
    output logic [N-1:0] remainder_o
);
    import mdu_pkg::*;

    localparam int CNT_W = $clog2(N);

    div_states_e      state;
    logic [CNT_W-1:0] counter;

    logic             sign_a, sign_b;
    logic             neg_quo, neg_rem;
    logic             divide_by_zero, divide_by_one, overflow, special;

    logic [N-1:0]     a_unsig, b_unsig;
    logic [N-1:0]     acc, next_acc;
    logic [N-1:0]     quo, next_quo;
    logic [N:0]       shifted;
    logic [N:0]       diff;

    assign sign_a = dividend_i[N-1] & signed_i;
    assign sign_b = divisor_i[N-1]  & signed_i;

    assign divide_by_zero = (divisor_i == '0);
    assign divide_by_one  = (divisor_i == N'(1));
    // most negative value divided by minus one, any width.
    assign overflow       = signed_i && (divisor_i == '1) &&
                            (dividend_i == {1'b1, {(N-1){1'b0}}});
    assign special        = divide_by_zero | divide_by_one | overflow;

    // one restoring step: shift in the next dividend bit, subtract if it fits.
    assign shifted = {acc, quo[N-1]};
    assign diff    = shifted - {1'b0, b_unsig};

    always_comb begin
        if (shifted >= {1'b0, b_unsig}) begin
            next_acc = diff[N-1:0];
            next_quo = {quo[N-2:0], 1'b1};
        end else begin
            next_acc = shifted[N-1:0];
            next_quo = {quo[N-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= D_IDLE;
            counter <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start_i) begin
                        if (special)
                            done_o <= 1'b1;     // shortcut, no iterations.
                        else
                            state  <= D_INIT;
                    end
                end
                D_INIT: begin
                    state   <= D_CALC;
                    counter <= '0;
                end
                D_CALC: begin
                    counter <= counter + 1'b1;
                    if (counter == CNT_W'(N-1))
                        state <= D_SIGN;
                end
                D_SIGN: begin
                    state  <= D_IDLE;
                    done_o <= 1'b1;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            D_IDLE: begin
                if (start_i) begin
                    neg_quo <= sign_a ^ sign_b;
                    neg_rem <= sign_a;      // remainder follows the dividend.
                    a_unsig <= sign_a ? -dividend_i : dividend_i;
                    b_unsig <= sign_b ? -divisor_i  : divisor_i;
                    if (divide_by_zero) begin
                        quotient_o  <= '1;
                        remainder_o <= dividend_i;
                    end else if (divide_by_one | overflow) begin
                        quotient_o  <= dividend_i;
                        remainder_o <= '0;
                    end
                end
            end
            D_INIT: begin
                acc <= '0;
                quo <= a_unsig;
            end
            D_CALC: begin
                acc <= next_acc;
                quo <= next_quo;
            end
            D_SIGN: begin
                quotient_o  <= neg_quo ? -quo : quo;
                remainder_o <= neg_rem ? -acc : acc;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/mdu_writeback.sv
`timescale 1ns/1ps

module mdu_writeback #(
    parameter int N = 32
) (
    input  logic               clk,
    input  logic               reset_n,
    input  rv32m_pkg::mdu_op_e op_i,
    input  logic               mul_done_i,
    input  logic [2*N-1:0]     product_i,
    input  logic               div_done_i,
    input  logic [N-1:0]       quotient_i,
    input  logic [N-1:0]       remainder_i,
    output logic               valid_o,
    output logic [N-1:0]       result_o
);
    import rv32m_pkg::*;

    logic [N-1:0] result_sel;

    always_comb begin
        case (op_i)
            OP_MUL:                       result_sel = product_i[N-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU: result_sel = product_i[2*N-1:N];
            OP_DIV, OP_DIVU:              result_sel = quotient_i;
            default:                      result_sel = remainder_i;  // REM and REMU.
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= mul_done_i | div_done_i;  // single-cycle strobe.
        end
    end

    // only one unit is ever active, so either done strobe can load it.
    always_ff @(posedge clk) begin
        if (mul_done_i || div_done_i) begin
            result_o <= result_sel;
        end
    end

endmodule

// File: hdl/mdu_top.sv
`timescale 1ns/1ps

module mdu_top #(
    parameter int N = mdu_pkg::XLEN_DEFAULT
) (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         valid_i,
    input  logic [2:0]   funct3_i,
    input  logic [N-1:0] rs1_i,
    input  logic [N-1:0] rs2_i,
    output logic         busy_o,
    output logic         valid_o,
    output logic [N-1:0] result_o
);
    import rv32m_pkg::*;

    mdu_op_e        op;
    logic           mul_start, div_start;
    logic [N-1:0]   operand_a, operand_b;
    logic           a_signed, b_signed;
    logic           mul_done, div_done;
    logic [2*N-1:0] product;
    logic [N-1:0]   quotient, remainder;

    mdu_decode #(.N(N)) u_decode (
        .clk         (clk),
        .reset_n     (reset_n),
        .valid_i     (valid_i),
        .funct3_i    (funct3_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .wb_valid_i  (valid_o),
        .busy_o      (busy_o),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .op_o        (op),
        .operand_a_o (operand_a),
        .operand_b_o (operand_b),
        .a_signed_o  (a_signed),
        .b_signed_o  (b_signed)
    );

    mul_unit #(.N(N)) u_mul (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (mul_start),
        .a_i        (operand_a),
        .b_i        (operand_b),
        .a_signed_i (a_signed),
        .b_signed_i (b_signed),
        .done_o     (mul_done),
        .product_o  (product)
    );

    // DIV and REM set both flags, so the dividend flag gives signedness.
    div_unit #(.N(N)) u_div (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (div_start),
        .dividend_i  (operand_a),
        .divisor_i   (operand_b),
        .signed_i    (a_signed),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    mdu_writeback #(.N(N)) u_writeback (
        .clk         (clk),
        .reset_n     (reset_n),
        .op_i        (op),
        .mul_done_i  (mul_done),
        .product_i   (product),
        .div_done_i  (div_done),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .valid_o     (valid_o),
        .result_o    (result_o)
    );

endmodule

// File: tb/mdu_assertions.sv
`timescale 1ns/1ps

module mdu_assertions (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 valid_i,
    input logic                 busy_o,
    input logic                 valid_o,
    input mdu_pkg::div_states_e div_state
);
    import mdu_pkg::*;

    int   error_count = 0;  // read by the testbench.
    logic issued;           // first issue strobe seen since reset.

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            issued <= 1'b0;
        else if (valid_i)
            issued <= 1'b1;
    end

    single_valid: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o |=> !valid_o)
        else begin
            $error("valid_o high for two consecutive cycles");
            error_count++;
        end

    valid_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o |-> busy_o)
        else begin
            $error("valid_o pulsed while busy_o was low");
            error_count++;
        end

    idle_after_reset: assert property (@(posedge clk) disable iff (!reset_n)
        !issued |-> !busy_o)
        else begin
            $error("busy_o rose before any issue strobe");
            error_count++;
        end

    // the divider only leaves D_IDLE while an operation is in flight.
    legal_div_state: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(div_state) && (busy_o || div_state == D_IDLE))
        else begin
            $error("divider left its legal states");
            error_count++;
        end

endmodule

bind mdu_top mdu_assertions u_mdu_assertions (
    .clk       (clk),
    .reset_n   (reset_n),
    .valid_i   (valid_i),
    .busy_o    (busy_o),
    .valid_o   (valid_o),
    .div_state (u_div.state)
);

// File: tb/mdu_tb.sv
`timescale 1ns/1ps

module mdu_tb;
    import rv32m_pkg::*;

    localparam int N          = 32;
    localparam int NUM_RANDOM = 400;
    localparam int NUM_OPS    = 12 + NUM_RANDOM;    // directed divider cases first.
    localparam int TIMEOUT    = NUM_OPS * (N + 10) + 1000;
    localparam logic [N-1:0] MIN_VAL = {1'b1, {(N-1){1'b0}}};

    logic         clk, reset_n, valid_i;
    logic [2:0]   funct3_i;
    logic [N-1:0] rs1_i, rs2_i;
    logic         busy_o, valid_o;
    logic [N-1:0] result_o;

    // one entry per accepted issue, popped at valid_o.
    logic [N-1:0] exp_q[$];
    int           lat_q[$];
    int           issue_q[$];
    string        name_q[$];
    int           cycle = 0;
    int           issued = 0;
    int           results = 0;

    mdu_top #(.N(N)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;   // number of rising edges so far.

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // RISC-V M rules with truncating division and a remainder that keeps the dividend sign.
    function automatic logic [N-1:0] model_result(input logic [2:0] f3,
                                                  input logic [N-1:0] a, b);
        logic [2*N-1:0]      ss, su, uu;
        logic signed [N-1:0] sq, sr;
        logic                overflow;
        overflow = (a == MIN_VAL) && (b == '1);
        ss = $signed(a) * $signed(b);
        su = $signed(a) * $signed({1'b0, b});
        uu = a * b;
        sq = '0;
        sr = '0;
        if (b != '0 && !overflow) begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (f3)
            FUNCT3_MUL:    return ss[N-1:0];
            FUNCT3_MULH:   return ss[2*N-1:N];
            FUNCT3_MULHSU: return su[2*N-1:N];
            FUNCT3_MULHU:  return uu[2*N-1:N];
            FUNCT3_DIV:    return (b == '0) ? '1 : (overflow ? a : sq);
            FUNCT3_DIVU:   return (b == '0) ? '1 : a / b;
            FUNCT3_REM:    return (b == '0) ? a : (overflow ? '0 : sr);
            default:       return (b == '0) ? a : a % b;
        endcase
    endfunction

    function automatic int model_latency(input logic [2:0] f3, input logic [N-1:0] a, b);
        if (!f3[2] || b == '0 || b == N'(1))
            return 3;
        if ((f3 == FUNCT3_DIV || f3 == FUNCT3_REM) && a == MIN_VAL && b == '1)
            return 3;   // signed overflow shortcut.
        return N + 5;
    endfunction

    // biased toward the values that stress sign and special-case handling.
    function automatic logic [N-1:0] pick_operand();
        case ($urandom % 8)
            0:       return '0;
            1:       return N'(1);
            2:       return '1;
            3:       return MIN_VAL;
            4:       return N'($urandom % 16);
            5:       return -N'($urandom % 16);
            default: return N'($urandom);
        endcase
    endfunction

    task automatic issue(input logic [2:0] f3, input logic [N-1:0] a, b, input string kind);
        do @(negedge clk); while (busy_o);
        @(posedge clk);
        valid_i  <= 1'b1;
        funct3_i <= f3;
        rs1_i    <= a;
        rs2_i    <= b;
        exp_q.push_back(model_result(f3, a, b));
        lat_q.push_back(model_latency(f3, a, b));
        issue_q.push_back(cycle + 1);   // index of this edge.
        name_q.push_back($sformatf("%s funct3=%0d", kind, f3));
        issued++;
        @(posedge clk);
        valid_i <= 1'b0;
        if ($urandom % 3 == 0) begin
            @(negedge clk);
            if (busy_o && !valid_o) begin   // busy is sure to hold one more edge.
                @(posedge clk);
                valid_i  <= 1'b1;
                funct3_i <= 3'($urandom);
                rs1_i    <= N'($urandom);
                rs2_i    <= N'($urandom);
                @(posedge clk);
                valid_i <= 1'b0;
            end
        end
    endtask

    always @(negedge clk) begin : monitor
        logic [N-1:0] expected;
        int           lat;
        string        name;
        assert (dut0.u_mdu_assertions.error_count == 0)
            else report_failure("a bound handshake assertion failed");
        if (reset_n && valid_o) begin
            assert (exp_q.size() > 0)
                else report_failure("valid_o pulsed with no operation in flight");
            expected = exp_q.pop_front();
            name     = name_q.pop_front();
            lat      = cycle - issue_q.pop_front();
            assert (result_o == expected)
                else report_failure($sformatf("mismatch %s: expected %h, actual %h",
                                              name, expected, result_o));
            assert (lat == lat_q[0])
                else report_failure($sformatf("mismatch %s latency: expected %0d, actual %0d",
                                              name, lat_q[0], lat));
            void'(lat_q.pop_front());
            results++;
        end
    end

    initial begin : stimulus
        int dummy;
        dummy    = $urandom(82);
        reset_n  = 1'b0;
        valid_i  = 1'b0;
        funct3_i = '0;
        rs1_i    = '0;
        rs2_i    = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        assert (!busy_o && !valid_o) else report_failure("busy_o or valid_o high after reset");
        for (int d = 4; d < 8; d++) begin
            issue(3'(d), pick_operand(), '0, "divide by zero");
            issue(3'(d), pick_operand(), N'(1), "divide by one");
            issue(3'(d), MIN_VAL, '1, "most negative by minus one");
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            issue(3'($urandom), pick_operand(), pick_operand(), "random");
            if ($urandom % 2 == 0) begin
                do @(negedge clk); while (busy_o);
                @(posedge clk);   // one idle cycle before the next issue.
            end
        end
        while (exp_q.size() > 0) @(negedge clk);
        repeat (N + 10) @(negedge clk);   // a late extra result would show here.
        assert (results == issued) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_failure($sformatf("mismatch result count: expected %0d, actual %0d",
                                     issued, results));
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT) @(posedge clk);
        report_failure($sformatf("timeout: operations still pending after %0d cycles",
                                 TIMEOUT));
    end

endmodule

// File: flist.f
hdl/rv32m_pkg.sv
hdl/mdu_pkg.sv
hdl/mdu_decode.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/mdu_writeback.sv
hdl/mdu_top.sv
tb/mdu_assertions.sv
tb/mdu_tb.sv
